/* compile.f */
hw/board_pkg.sv
hw/video_pkg.sv
hw/piece_shape.sv
hw/cell_probe.sv
hw/playfield_store.sv
hw/game_ctrl.sv
hw/pixel_render.sv
hw/tetris_top.sv
verification/tetris_chk.sv
verification/tetris_tb.sv

/* hw/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Playfield geometry
    localparam int BOARD_COLS = 10;
    localparam int BOARD_ROWS = 20;

    // Anchor of a freshly spawned piece
    localparam int SPAWN_COL = 4;
    localparam int SPAWN_ROW = 1;

    // Signed so that a candidate one step outside the field is representable
    typedef logic signed [4:0] col_t;
    typedef logic signed [5:0] row_t;

    // 0 is an empty cell
    typedef logic [2:0] color_code_t;

    typedef logic [1:0] rot_t;

    typedef enum logic [2:0] {
        S_ZIG,
        S_ZAG,
        S_TEE,
        S_BAR,
        S_ELL,
        S_JAY,
        S_BOX
    } shape_e;

    // Keyboard scan codes
    typedef enum logic [7:0] {
        KEY_LEFT  = 8'h6b,
        KEY_DOWN  = 8'h72,
        KEY_RIGHT = 8'h74,
        KEY_UP    = 8'h75
    } key_e;

    typedef enum logic [2:0] {
        ST_WAIT,
        ST_EVAL,
        ST_LOCK,
        ST_CLEAR,
        ST_SPAWN
    } game_state_e;

endpackage

`default_nettype wire

/* hw/cell_probe.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_probe (
    input  board_pkg::col_t        i_col,
    input  board_pkg::row_t        i_row,
    output logic [3:0]             o_rd_col,
    output logic [4:0]             o_rd_row,
    input  board_pkg::color_code_t i_rd_code,
    output logic                   o_ok
);
    import board_pkg::*;

    logic in_bounds;

    assign in_bounds = (i_col >= 0) && (i_col < BOARD_COLS) &&
                       (i_row >= 0) && (i_row < BOARD_ROWS);

    // Out-of-field cells read cell (0,0), the result is masked anyway
    assign o_rd_col = in_bounds ? i_col[3:0] : 4'd0;
    assign o_rd_row = in_bounds ? i_row[4:0] : 5'd0;

    assign o_ok = in_bounds && (i_rd_code == '0);

endmodule

`default_nettype wire

/* hw/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ctrl #(
    parameter int GRAVITY_TICKS = 2500000
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  board_pkg::key_e        i_key,
    input  logic                   i_key_valid,
    input  logic                   i_pause,
    input  logic [3:0]             i_cells_ok,
    output board_pkg::col_t        o_cand_col,
    output board_pkg::row_t        o_cand_row,
    output board_pkg::shape_e      o_cand_shape,
    output board_pkg::rot_t        o_cand_rot,
    output board_pkg::col_t        o_cur_col,
    output board_pkg::row_t        o_cur_row,
    output board_pkg::shape_e      o_cur_shape,
    output board_pkg::rot_t        o_cur_rot,
    output logic                   o_lock_we,
    output board_pkg::color_code_t o_lock_code,
    output logic [4:0]             o_scan_row,
    input  logic                   i_row_full,
    output logic                   o_row_shift,
    output logic                   o_ready
);
    import board_pkg::*;

    localparam int GW = $clog2(GRAVITY_TICKS + 1);

    game_state_e   state;
    logic [GW-1:0] grav_cnt;

    // Shape never changes with a move
    assign o_cand_shape = o_cur_shape;
    assign o_lock_code  = color_code_t'(o_cur_shape) + 3'd1;

    assign o_ready     = (state == ST_WAIT);
    assign o_lock_we   = (state == ST_LOCK) && !i_pause;
    assign o_row_shift = (state == ST_CLEAR) && i_row_full && !i_pause;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_WAIT;
            grav_cnt    <= '0;
            o_scan_row  <= '0;
            o_cur_shape <= S_ZIG;
            o_cur_rot   <= '0;
            o_cur_col   <= col_t'(SPAWN_COL);
            o_cur_row   <= row_t'(SPAWN_ROW);
            o_cand_rot  <= '0;
            o_cand_col  <= col_t'(SPAWN_COL);
            o_cand_row  <= row_t'(SPAWN_ROW);
        end else if (!i_pause) begin
            case (state)
                ST_WAIT: begin
                    o_cand_col <= o_cur_col;
                    o_cand_row <= o_cur_row;
                    o_cand_rot <= o_cur_rot;
                    if (i_key_valid) begin
                        grav_cnt <= '0;
                        state    <= ST_EVAL;
                        case (i_key)
                            KEY_LEFT:  o_cand_col <= o_cur_col - col_t'(1);
                            KEY_RIGHT: o_cand_col <= o_cur_col + col_t'(1);
                            KEY_UP:    o_cand_rot <= o_cur_rot + rot_t'(1);
                            KEY_DOWN:  o_cand_row <= o_cur_row + row_t'(1);
                            default: ;
                        endcase
                    end else if (grav_cnt == GW'(GRAVITY_TICKS - 1)) begin
                        grav_cnt   <= '0;
                        o_cand_row <= o_cur_row + row_t'(1);
                        state      <= ST_EVAL;
                    end else begin
                        grav_cnt <= grav_cnt + 1'b1;
                    end
                end
                ST_EVAL: begin
                    if (&i_cells_ok) begin
                        o_cur_col <= o_cand_col;
                        o_cur_row <= o_cand_row;
                        o_cur_rot <= o_cand_rot;
                        state     <= ST_WAIT;
                    end else if (o_cand_row != o_cur_row) begin
                        // Blocked on the way down
                        state <= ST_LOCK;
                    end else begin
                        state <= ST_WAIT;
                    end
                end
                ST_LOCK: begin
                    o_scan_row <= '0;
                    state      <= ST_CLEAR;
                end
                ST_CLEAR: begin
                    if (o_scan_row == 5'(BOARD_ROWS - 1)) begin
                        state <= ST_SPAWN;
                    end else begin
                        o_scan_row <= o_scan_row + 5'd1;
                    end
                end
                ST_SPAWN: begin
                    o_cur_shape <= (o_cur_shape == S_BOX) ? S_ZIG :
                                   shape_e'(o_cur_shape + 3'd1);
                    o_cur_rot   <= '0;
                    o_cur_col   <= col_t'(SPAWN_COL);
                    o_cur_row   <= row_t'(SPAWN_ROW);
                    state       <= ST_WAIT;
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/piece_shape.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_shape (
    input  board_pkg::col_t   i_col,
    input  board_pkg::row_t   i_row,
    input  board_pkg::shape_e i_shape,
    input  board_pkg::rot_t   i_rot,
    output board_pkg::col_t   o_cell_col [4],
    output board_pkg::row_t   o_cell_row [4]
);
    import board_pkg::*;

    // Offsets of cells 1 to 3 from the anchor
    int dx [3];
    int dy [3];

    always_comb begin
        case (i_shape)
            S_ZIG: begin
                if (!i_rot[0]) begin
                    dx = '{-1, 0, 1};
                    dy = '{0, 1, 1};
                end else begin
                    dx = '{0, -1, -1};
                    dy = '{-1, 0, 1};
                end
            end
            S_ZAG: begin
                if (!i_rot[0]) begin
                    dx = '{-1, 0, 1};
                    dy = '{1, 1, 0};
                end else begin
                    dx = '{-1, -1, 0};
                    dy = '{-1, 0, 1};
                end
            end
            S_TEE: begin
                case (i_rot)
                    2'd0: begin
                        dx = '{-1, 0, 1};
                        dy = '{0, 1, 0};
                    end
                    2'd1: begin
                        dx = '{-1, 0, 0};
                        dy = '{0, -1, 1};
                    end
                    2'd2: begin
                        dx = '{-1, 0, 1};
                        dy = '{0, -1, 0};
                    end
                    default: begin
                        dx = '{0, 1, 0};
                        dy = '{-1, 0, 1};
                    end
                endcase
            end
            S_BAR: begin
                if (!i_rot[0]) begin
                    dx = '{-1, 1, 2};
                    dy = '{0, 0, 0};
                end else begin
                    dx = '{0, 0, 0};
                    dy = '{-1, 1, 2};
                end
            end
            S_ELL: begin
                case (i_rot)
                    2'd0: begin
                        dx = '{-1, 1, 1};
                        dy = '{0, 0, 1};
                    end
                    2'd1: begin
                        dx = '{-1, 0, 0};
                        dy = '{1, -1, 1};
                    end
                    2'd2: begin
                        dx = '{-1, -1, 1};
                        dy = '{-1, 0, 0};
                    end
                    default: begin
                        dx = '{0, 0, 1};
                        dy = '{-1, 1, -1};
                    end
                endcase
            end
            S_JAY: begin
                case (i_rot)
                    2'd0: begin
                        dx = '{-1, -1, 1};
                        dy = '{0, 1, 0};
                    end
                    2'd1: begin
                        dx = '{-1, 0, 0};
                        dy = '{-1, -1, 1};
                    end
                    2'd2: begin
                        dx = '{-1, 1, 1};
                        dy = '{0, 0, -1};
                    end
                    default: begin
                        dx = '{0, 0, 1};
                        dy = '{-1, 1, 1};
                    end
                endcase
            end
            // Box looks the same in every rotation
            default: begin
                dx = '{0, 1, 1};
                dy = '{1, 0, 1};
            end
        endcase
    end

    always_comb begin
        o_cell_col[0] = i_col;
        o_cell_row[0] = i_row;
        for (int k = 0; k < 3; k++) begin
            o_cell_col[k + 1] = i_col + col_t'(dx[k]);
            o_cell_row[k + 1] = i_row + row_t'(dy[k]);
        end
    end

endmodule

`default_nettype wire

/* hw/pixel_render.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_render (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  video_pkg::pix_t        i_x,
    input  video_pkg::pix_t        i_y,
    input  board_pkg::col_t        i_piece_col [4],
    input  board_pkg::row_t        i_piece_row [4],
    input  board_pkg::color_code_t i_piece_code,
    output logic [3:0]             o_rd_col,
    output logic [4:0]             o_rd_row,
    input  board_pkg::color_code_t i_rd_code,
    output video_pkg::rgb_t        o_rgb
);
    import board_pkg::*;
    import video_pkg::*;

    pix_t dx;
    pix_t dy;
    pix_t cell_x;
    pix_t cell_y;
    logic in_field;
    logic on_grid;
    logic on_piece;
    rgb_t rgb_next;

    assign dx     = i_x - pix_t'(FIELD_X0);
    assign dy     = i_y - pix_t'(FIELD_Y0);
    assign cell_x = dx / pix_t'(CELL_PX);
    assign cell_y = dy / pix_t'(CELL_PX);

    // Right and bottom edges included so the closing grid line shows
    assign in_field = (i_x >= pix_t'(FIELD_X0)) && (i_x <= pix_t'(FIELD_X0 + FIELD_W)) &&
                      (i_y >= pix_t'(FIELD_Y0)) && (i_y <= pix_t'(FIELD_Y0 + FIELD_H));
    assign on_grid  = (dx % pix_t'(CELL_PX) == '0) || (dy % pix_t'(CELL_PX) == '0);

    // Off the grid inside the field, the cell index is always legal
    assign o_rd_col = (in_field && !on_grid) ? cell_x[3:0] : 4'd0;
    assign o_rd_row = (in_field && !on_grid) ? cell_y[4:0] : 5'd0;

    always_comb begin
        on_piece = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if ((i_piece_col[k] == col_t'(cell_x)) && (i_piece_row[k] == row_t'(cell_y))) begin
                on_piece = 1'b1;
            end
        end
    end

    always_comb begin
        if (!in_field) begin
            rgb_next = BACK_RGB;
        end else if (on_grid) begin
            rgb_next = GRID_RGB;
        end else if (on_piece) begin
            rgb_next = code_to_rgb(i_piece_code);
        end else begin
            rgb_next = code_to_rgb(i_rd_code);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb <= '0;
        end else begin
            o_rgb <= rgb_next;
        end
    end

endmodule

`default_nettype wire

/* hw/playfield_store.sv */
`timescale 1ns/1ps
`default_nettype none

module playfield_store (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_lock_we,
    input  board_pkg::color_code_t i_lock_code,
    input  board_pkg::col_t        i_lock_col [4],
    input  board_pkg::row_t        i_lock_row [4],
    input  logic [4:0]             i_scan_row,
    output logic                   o_row_full,
    input  logic                   i_row_shift,
    input  logic [3:0]             i_rd_col [5],
    input  logic [4:0]             i_rd_row [5],
    output board_pkg::color_code_t o_rd_code [5]
);
    import board_pkg::*;

    color_code_t cells [BOARD_ROWS][BOARD_COLS];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cells <= '{default: '0};
        end else if (i_lock_we) begin
            for (int k = 0; k < 4; k++) begin
                cells[i_lock_row[k][4:0]][i_lock_col[k][3:0]] <= i_lock_code;
            end
        end else if (i_row_shift) begin
            // Rows above the full one drop by one, the top row empties
            for (int r = 1; r < BOARD_ROWS; r++) begin
                if (5'(r) <= i_scan_row) begin
                    cells[r] <= cells[r - 1];
                end
            end
            cells[0] <= '{default: '0};
        end
    end

    always_comb begin
        o_row_full = 1'b1;
        for (int c = 0; c < BOARD_COLS; c++) begin
            if (cells[i_scan_row][c] == '0) begin
                o_row_full = 1'b0;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 5; p++) begin
            o_rd_code[p] = cells[i_rd_row[p]][i_rd_col[p]];
        end
    end

endmodule

`default_nettype wire

/* hw/tetris_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_top #(
    parameter int GRAVITY_TICKS = 2500000
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  board_pkg::key_e i_key,
    input  logic            i_key_valid,
    input  logic            i_pause,
    input  video_pkg::pix_t i_x,
    input  video_pkg::pix_t i_y,
    output logic            o_ready,
    output video_pkg::rgb_t o_rgb
);
    import board_pkg::*;

    col_t        cand_col;
    row_t        cand_row;
    shape_e      cand_shape;
    rot_t        cand_rot;
    col_t        cur_col;
    row_t        cur_row;
    shape_e      cur_shape;
    rot_t        cur_rot;
    col_t        cand_cell_col [4];
    row_t        cand_cell_row [4];
    col_t        cur_cell_col [4];
    row_t        cur_cell_row [4];
    logic [3:0]  cells_ok;
    logic        lock_we;
    color_code_t lock_code;
    logic [4:0]  scan_row;
    logic        row_full;
    logic        row_shift;

    // Read ports 0 to 3 serve the probes, port 4 the renderer
    logic [3:0]  rd_col [5];
    logic [4:0]  rd_row [5];
    color_code_t rd_code [5];

    game_ctrl #(
        .GRAVITY_TICKS(GRAVITY_TICKS)
    ) u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_key       (i_key),
        .i_key_valid (i_key_valid),
        .i_pause     (i_pause),
        .i_cells_ok  (cells_ok),
        .o_cand_col  (cand_col),
        .o_cand_row  (cand_row),
        .o_cand_shape(cand_shape),
        .o_cand_rot  (cand_rot),
        .o_cur_col   (cur_col),
        .o_cur_row   (cur_row),
        .o_cur_shape (cur_shape),
        .o_cur_rot   (cur_rot),
        .o_lock_we   (lock_we),
        .o_lock_code (lock_code),
        .o_scan_row  (scan_row),
        .i_row_full  (row_full),
        .o_row_shift (row_shift),
        .o_ready     (o_ready)
    );

    piece_shape u_cand_shape (
        .i_col     (cand_col),
        .i_row     (cand_row),
        .i_shape   (cand_shape),
        .i_rot     (cand_rot),
        .o_cell_col(cand_cell_col),
        .o_cell_row(cand_cell_row)
    );

    piece_shape u_cur_shape (
        .i_col     (cur_col),
        .i_row     (cur_row),
        .i_shape   (cur_shape),
        .i_rot     (cur_rot),
        .o_cell_col(cur_cell_col),
        .o_cell_row(cur_cell_row)
    );

    for (genvar g = 0; g < 4; g++) begin : g_probe
        cell_probe u_probe (
            .i_col    (cand_cell_col[g]),
            .i_row    (cand_cell_row[g]),
            .o_rd_col (rd_col[g]),
            .o_rd_row (rd_row[g]),
            .i_rd_code(rd_code[g]),
            .o_ok     (cells_ok[g])
        );
    end

    playfield_store u_store (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lock_we  (lock_we),
        .i_lock_code(lock_code),
        .i_lock_col (cur_cell_col),
        .i_lock_row (cur_cell_row),
        .i_scan_row (scan_row),
        .o_row_full (row_full),
        .i_row_shift(row_shift),
        .i_rd_col   (rd_col),
        .i_rd_row   (rd_row),
        .o_rd_code  (rd_code)
    );

    pixel_render u_render (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_piece_col (cur_cell_col),
        .i_piece_row (cur_cell_row),
        .i_piece_code(lock_code),
        .o_rd_col    (rd_col[4]),
        .o_rd_row    (rd_row[4]),
        .i_rd_code   (rd_code[4]),
        .o_rgb       (o_rgb)
    );

endmodule

`default_nettype wire

/* hw/video_pkg.sv */
`default_nettype none

package video_pkg;

    typedef logic [9:0] pix_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Screen position and size of the playfield
    localparam int FIELD_X0 = 220;
    localparam int FIELD_Y0 = 40;
    localparam int CELL_PX  = 20;
    localparam int FIELD_W  = 200;
    localparam int FIELD_H  = 400;

    localparam rgb_t GRID_RGB = '{r: 8'd255, g: 8'd255, b: 8'd255};
    localparam rgb_t BACK_RGB = '{r: 8'd20, g: 8'd20, b: 8'd20};

    // Board palette, code 0 blends into the background
    function automatic rgb_t code_to_rgb(board_pkg::color_code_t code);
        case (code)
            3'd1: return '{r: 8'd255, g: 8'd20, b: 8'd20};
            3'd2: return '{r: 8'd20, g: 8'd255, b: 8'd20};
            3'd3: return '{r: 8'd20, g: 8'd20, b: 8'd255};
            3'd4: return '{r: 8'd20, g: 8'd255, b: 8'd255};
            3'd5: return '{r: 8'd255, g: 8'd20, b: 8'd255};
            3'd6: return '{r: 8'd255, g: 8'd255, b: 8'd20};
            3'd7: return '{r: 8'd255, g: 8'd100, b: 8'd0};
            default: return BACK_RGB;
        endcase
    endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tetris_tb \
    -f compile.f \
    -o tetris_sim
./obj_dir/tetris_sim

/* verification/tetris_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_chk (
    input wire logic                   i_clk,
    input wire logic                   i_rst_n,
    input wire board_pkg::game_state_e i_state,
    input wire logic                   i_ready,
    input wire logic                   i_key_valid,
    input wire logic                   i_pause,
    input wire logic                   i_lock_we
);
    import board_pkg::*;

    int clr_cnt;

    // Length of the current row-clear scan
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clr_cnt <= 0;
        end else if (i_state == ST_CLEAR) begin
            clr_cnt <= clr_cnt + 1;
        end else begin
            clr_cnt <= 0;
        end
    end

    // An accepted key is evaluated on the next cycle
    a_key_starts_eval: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ready && i_key_valid && !i_pause) |=> (i_state == ST_EVAL))
        else $error("accepted key did not start an evaluation");

    a_lock_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_lock_we |=> !i_lock_we)
        else $error("lock write enable held longer than one cycle");

    a_clear_length: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_state == ST_CLEAR) |-> (clr_cnt == BOARD_ROWS))
        else $error("row-clear scan did not last one cycle per row");

endmodule

bind game_ctrl tetris_chk u_chk (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_state    (state),
    .i_ready    (o_ready),
    .i_key_valid(i_key_valid),
    .i_pause    (i_pause),
    .i_lock_we  (o_lock_we)
);

`default_nettype wire

/* verification/tetris_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_tb;
    import board_pkg::*;
    import video_pkg::*;

    localparam int GRAV = 40;
    localparam int MAX_CYCLES = 200000;

    // Offsets of cells 1 to 3 by (shape * 4 + rotation) * 3 + cell
    localparam int OFS_X [84] = '{
        -1, 0, 1, 0, -1, -1, -1, 0, 1, 0, -1, -1,
        -1, 0, 1, -1, -1, 0, -1, 0, 1, -1, -1, 0,
        -1, 0, 1, -1, 0, 0, -1, 0, 1, 0, 1, 0,
        -1, 1, 2, 0, 0, 0, -1, 1, 2, 0, 0, 0,
        -1, 1, 1, -1, 0, 0, -1, -1, 1, 0, 0, 1,
        -1, -1, 1, -1, 0, 0, -1, 1, 1, 0, 0, 1,
        0, 1, 1, 0, 1, 1, 0, 1, 1, 0, 1, 1};
    localparam int OFS_Y [84] = '{
        0, 1, 1, -1, 0, 1, 0, 1, 1, -1, 0, 1,
        1, 1, 0, -1, 0, 1, 1, 1, 0, -1, 0, 1,
        0, 1, 0, 0, -1, 1, 0, -1, 0, -1, 0, 1,
        0, 0, 0, -1, 1, 2, 0, 0, 0, -1, 1, 2,
        0, 0, 1, 1, -1, 1, -1, 0, 0, -1, 1, -1,
        0, 1, 0, -1, -1, 1, 0, 0, -1, -1, 1, 1,
        1, 0, 1, 1, 0, 1, 1, 0, 1, 1, 0, 1};

    logic i_clk;
    logic i_rst_n;
    key_e i_key;
    logic i_key_valid;
    logic i_pause;
    pix_t i_x;
    pix_t i_y;
    logic o_ready;
    rgb_t o_rgb;

    // Reference game state
    logic [2:0] mb [BOARD_ROWS][BOARD_COLS];
    int pc;
    int pr;
    int ps;
    int prot;
    int locks;
    int cycles;
    int seed;

    tetris_top #(
        .GRAVITY_TICKS(GRAV)
    ) i_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_key      (i_key),
        .i_key_valid(i_key_valid),
        .i_pause    (i_pause),
        .i_x        (i_x),
        .i_y        (i_y),
        .o_ready    (o_ready),
        .o_rgb      (o_rgb)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_failure("Timeout: the run exceeded its cycle limit");
        end
    end

    task automatic check_rgb(string name, rgb_t exp, rgb_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic int cell_c(int c, int s, int rot, int k);
        if (k == 0) return c;
        return c + OFS_X[(s * 4 + rot) * 3 + k - 1];
    endfunction

    function automatic int cell_r(int r, int s, int rot, int k);
        if (k == 0) return r;
        return r + OFS_Y[(s * 4 + rot) * 3 + k - 1];
    endfunction

    function automatic bit fits(int c, int r, int rot);
        int x;
        int y;
        for (int k = 0; k < 4; k++) begin
            x = cell_c(c, ps, rot, k);
            y = cell_r(r, ps, rot, k);
            if (x < 0 || x >= BOARD_COLS || y < 0 || y >= BOARD_ROWS) return 1'b0;
            if (mb[y][x] != 3'd0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic lock_piece();
        bit full;
        for (int k = 0; k < 4; k++) begin
            mb[cell_r(pr, ps, prot, k)][cell_c(pc, ps, prot, k)] = 3'(ps + 1);
        end
        // Top-to-bottom scan in one pass
        for (int r = 0; r < BOARD_ROWS; r++) begin
            full = 1'b1;
            for (int c = 0; c < BOARD_COLS; c++) begin
                if (mb[r][c] == 3'd0) full = 1'b0;
            end
            if (full) begin
                for (int rr = r; rr > 0; rr--) mb[rr] = mb[rr - 1];
                for (int c = 0; c < BOARD_COLS; c++) mb[0][c] = 3'd0;
            end
        end
        ps = (ps + 1) % 7;
        prot = 0;
        pc = SPAWN_COL;
        pr = SPAWN_ROW;
        locks++;
    endtask

    task automatic model_key(key_e k);
        int nc;
        int nr;
        int nrot;
        nc = pc;
        nr = pr;
        nrot = prot;
        case (k)
            KEY_LEFT: nc = pc - 1;
            KEY_RIGHT: nc = pc + 1;
            KEY_UP: nrot = (prot + 1) % 4;
            default: nr = pr + 1;
        endcase
        if (fits(nc, nr, nrot)) begin
            pc = nc;
            pr = nr;
            prot = nrot;
        end else if (k == KEY_DOWN) begin
            lock_piece();
        end
    endtask

    function automatic rgb_t pal(int code);
        case (code)
            1: return rgb_t'({8'd255, 8'd20, 8'd20});
            2: return rgb_t'({8'd20, 8'd255, 8'd20});
            3: return rgb_t'({8'd20, 8'd20, 8'd255});
            4: return rgb_t'({8'd20, 8'd255, 8'd255});
            5: return rgb_t'({8'd255, 8'd20, 8'd255});
            6: return rgb_t'({8'd255, 8'd255, 8'd20});
            7: return rgb_t'({8'd255, 8'd100, 8'd0});
            default: return rgb_t'({8'd20, 8'd20, 8'd20});
        endcase
    endfunction

    function automatic rgb_t ref_rgb(int x, int y);
        int dx;
        int dy;
        if (x < FIELD_X0 || x > FIELD_X0 + 200 || y < FIELD_Y0 || y > FIELD_Y0 + 400) begin
            return rgb_t'({8'd20, 8'd20, 8'd20});
        end
        dx = x - FIELD_X0;
        dy = y - FIELD_Y0;
        if (dx % 20 == 0 || dy % 20 == 0) return rgb_t'({8'd255, 8'd255, 8'd255});
        for (int k = 0; k < 4; k++) begin
            if (cell_c(pc, ps, prot, k) == dx / 20 && cell_r(pr, ps, prot, k) == dy / 20) begin
                return pal(ps + 1);
            end
        end
        return pal(int'(mb[dy / 20][dx / 20]));
    endfunction

    // Each fed pixel checks the result of the one before
    bit   have_prev;
    rgb_t prev_exp;

    task automatic feed_pixel(string name, int x, int y);
        if (have_prev) check_rgb(name, prev_exp, o_rgb);
        i_x = pix_t'(x);
        i_y = pix_t'(y);
        prev_exp = ref_rgb(x, y);
        have_prev = 1'b1;
        @(negedge i_clk);
    endtask

    task automatic scan_screen(string name);
        i_pause = 1'b1;
        have_prev = 1'b0;
        @(negedge i_clk);
        for (int r = 0; r < BOARD_ROWS; r++) begin
            for (int c = 0; c < BOARD_COLS; c++) begin
                feed_pixel(name, FIELD_X0 + 10 + 20 * c, FIELD_Y0 + 10 + 20 * r);
            end
        end
        for (int i = 0; i <= 10; i++) begin
            feed_pixel(name, FIELD_X0 + 20 * i, FIELD_Y0 + 5);
            feed_pixel(name, FIELD_X0 + 5, FIELD_Y0 + 40 * i);
        end
        feed_pixel(name, 0, 0);
        feed_pixel(name, FIELD_X0 - 1, 100);
        feed_pixel(name, FIELD_X0 + 201, 100);
        feed_pixel(name, 300, FIELD_Y0 + 401);
        feed_pixel(name, 639, 479);
        check_rgb(name, prev_exp, o_rgb);
        i_pause = 1'b0;
    endtask

    task automatic send_key(key_e k);
        int locks_before;
        check_ready("key sent while ready", 1'b1, o_ready);
        locks_before = locks;
        i_key = k;
        i_key_valid = 1'b1;
        @(negedge i_clk);
        i_key_valid = 1'b0;
        check_ready("busy after key", 1'b0, o_ready);
        model_key(k);
        if (locks == locks_before) begin
            @(negedge i_clk);
            check_ready("ready one cycle after move", 1'b1, o_ready);
        end else begin
            while (!o_ready) @(negedge i_clk);
        end
    endtask

    task automatic wait_gravity();
        int idle;
        idle = 0;
        while (o_ready) begin
            @(negedge i_clk);
            idle++;
            if (idle > GRAV) report_failure("Gravity step did not start in time");
        end
        if (idle != GRAV) report_failure("Gravity step started too early");
        while (!o_ready) @(negedge i_clk);
        model_key(KEY_DOWN);
    endtask

    initial begin
        int v;
        int start_locks;
        seed = 32'hce56c00d;
        i_rst_n = 1'b0;
        i_key = KEY_DOWN;
        i_key_valid = 1'b0;
        i_pause = 1'b0;
        i_x = '0;
        i_y = '0;
        cycles = 0;
        locks = 0;
        have_prev = 1'b0;
        prev_exp = '0;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            for (int c = 0; c < BOARD_COLS; c++) mb[r][c] = 3'd0;
        end
        ps = 0;
        prot = 0;
        pc = SPAWN_COL;
        pr = SPAWN_ROW;
        repeat (10) @(negedge i_clk);
        check_rgb("rgb in reset", '0, o_rgb);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_ready("ready after reset", 1'b1, o_ready);
        scan_screen("reset screen");

        repeat (6) send_key(KEY_RIGHT);
        scan_screen("right wall");
        repeat (8) send_key(KEY_LEFT);
        scan_screen("left wall");

        send_key(KEY_UP);
        scan_screen("rotate 1");
        send_key(KEY_UP);
        send_key(KEY_UP);
        scan_screen("rotate 3");
        // Upright zig against the right wall has no room to lie flat
        repeat (9) send_key(KEY_RIGHT);
        send_key(KEY_UP);
        scan_screen("rotate at wall");

        start_locks = locks;
        while (locks == start_locks) send_key(KEY_DOWN);
        scan_screen("lock and spawn");
        send_key(KEY_UP);
        repeat (3) send_key(KEY_LEFT);
        start_locks = locks;
        while (locks == start_locks) send_key(KEY_DOWN);
        // Upright tee beside the locked zig, turning would overlap it
        send_key(KEY_UP);
        repeat (3) send_key(KEY_RIGHT);
        repeat (17) send_key(KEY_DOWN);
        send_key(KEY_UP);
        scan_screen("rotate against stack");
        send_key(KEY_DOWN);

        send_key(KEY_RIGHT);
        wait_gravity();
        scan_screen("gravity step");
        repeat (5) begin
            @(negedge i_clk);
            check_ready("ready after gravity", 1'b1, o_ready);
        end
        i_pause = 1'b1;
        repeat (3 * GRAV) begin
            @(negedge i_clk);
            check_ready("ready while paused", 1'b1, o_ready);
        end
        scan_screen("paused screen");

        for (int i = 0; i < 600; i++) begin
            v = ($random(seed) & 32'h7fffffff) % 10;
            if (v < 3) send_key(KEY_LEFT);
            else if (v < 6) send_key(KEY_RIGHT);
            else if (v < 7) send_key(KEY_UP);
            else send_key(KEY_DOWN);
            if (i % 20 == 19) scan_screen($sformatf("random key %0d", i));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
